// ==== rob_commit_sel.sv ====
module rob_commit_sel
  import rob_pkg::*;
(
  input  rob_entry_t              i_head,
  input  logic [ROB_ID_W_DEF-1:0] i_head_id,
  input  logic                    i_all_done,
  input  logic                    i_killing,
  output commit_t                 o_commit,
  output rnid_upd_t               o_rnid_upd
);

  localparam int SLOT_W = $clog2(DISP_SIZE);

  logic [DISP_SIZE-1:0] w_upd_valid;
  logic [DISP_SIZE-1:0] w_sel_oh;
  logic [DISP_SIZE-1:0] w_except_oh;
  logic [DISP_SIZE-1:0] w_br_oh;
  logic [DISP_SIZE-1:0] w_above;
  logic [DISP_SIZE-1:0] w_dead_id;
  logic [DISP_SIZE-1:0] w_live;
  logic [SLOT_W-1:0]    w_sel_idx;
  logic [3:0]           w_type_or;
  logic [PC_W-1:0]      w_tval_or;
  logic [PC_W-1:0]      w_target_or;
  logic [PC_W-1:0]      w_epc;
  except_t              w_except_type;
  logic                 w_commit;
  logic                 w_fetch_except;

  // Dead heads drain only during the kill phase
  assign w_commit = i_all_done & (~i_head.dead | i_killing);

  // First slot that redirects the PC
  assign w_upd_valid = i_head.br_upd_valid | i_head.except_valid;
  assign w_sel_oh    = w_upd_valid & ~(w_upd_valid - DISP_SIZE'(1));
  assign w_except_oh = w_sel_oh & i_head.except_valid;
  assign w_br_oh     = w_sel_oh & i_head.br_upd_valid & ~i_head.except_valid;
  assign w_above     = ~(w_sel_oh | (w_sel_oh - DISP_SIZE'(1)));   // Slots after the selected one

  always_comb begin
    w_sel_idx   = '0;
    w_type_or   = '0;
    w_tval_or   = '0;
    w_target_or = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (w_sel_oh[d]) w_sel_idx = SLOT_W'(d);
      if (w_except_oh[d]) begin
        w_type_or |= i_head.except_type[d];
        w_tval_or |= i_head.tval[d];
      end
      if (w_br_oh[d]) w_target_or |= i_head.br_target[d];
    end
  end

  assign w_except_type  = except_t'(w_type_or);
  assign w_epc          = i_head.pc + {{(PC_W-SLOT_W-2){1'b0}}, w_sel_idx, 2'b00};
  assign w_fetch_except = w_except_type inside {INST_ADDR_MISALIGN, INST_ACC_FAULT,
                                                INST_PAGE_FAULT};

  // A dead head has every slot dead
  assign w_dead_id = i_head.dead ? i_head.grp_id : (w_above & i_head.grp_id);
  assign w_live    = i_head.grp_id & ~w_dead_id;

  always_comb begin
    o_commit.commit       = w_commit;
    o_commit.cmt_id       = i_head_id;
    o_commit.grp_id       = i_head.grp_id;
    o_commit.flush_valid  = (|w_sel_oh) & ~i_head.dead;
    o_commit.upd_pc_vaddr = (|w_except_oh) ? w_epc : w_target_or;
    o_commit.except_valid = (|w_except_oh) & ~i_head.dead;
    o_commit.except_type  = w_except_type;
    o_commit.epc          = w_epc;
    o_commit.tval         = w_fetch_except ? w_epc : w_tval_or;
    o_commit.dead_id      = w_dead_id;
    o_commit.all_dead     = i_head.dead;
  end

  always_comb begin
    o_rnid_upd.commit   = w_commit;
    o_rnid_upd.dead_id  = w_dead_id;
    o_rnid_upd.all_dead = i_head.dead;
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rnid_upd.rnid_valid[d] = w_live[d] & i_head.inst[d].rd_valid;
      o_rnid_upd.rd_regidx[d]  = i_head.inst[d].rd_regidx;
      o_rnid_upd.rd_rnid[d]    = i_head.inst[d].rd_rnid;
      o_rnid_upd.old_rnid[d]   = i_head.inst[d].rd_old_rnid;
    end
  end

endmodule

// ==== rob_credit.sv ====
module rob_credit #(
  parameter int  ROB_ENTRIES = 8,
  localparam int CNT_W       = $clog2(ROB_ENTRIES) + 1
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  logic             i_commit,
  output logic             o_credit_valid,
  output logic [CNT_W-1:0] o_credit_val
);

  logic [CNT_W-1:0] r_count;   // Groups held in the ROB
  logic             r_credit_valid;
  logic [CNT_W-1:0] r_credit_val;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      case ({i_disp_valid, i_commit})
        2'b10:   r_count <= r_count + CNT_W'(1);
        2'b01:   r_count <= r_count - CNT_W'(1);
        default: r_count <= r_count;
      endcase
    end
  end

  // One credit back per commit, a cycle later
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credit_valid <= 1'b0;
      r_credit_val   <= '0;
    end else begin
      r_credit_valid <= i_commit;
      r_credit_val   <= i_commit ? CNT_W'(1) : '0;
    end
  end

  assign o_credit_valid = r_credit_valid;
  assign o_credit_val   = r_credit_val;

  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_count <= CNT_W'(ROB_ENTRIES));

endmodule

// ==== rob_entry.sv ====
module rob_entry
  import rob_pkg::*;
#(
  parameter int  ROB_ENTRIES = 8,
  parameter int  ENTRY_IDX   = 0,
  localparam int IDX_W       = $clog2(ROB_ENTRIES),
  localparam int ROB_ID_W    = IDX_W + 1
) (
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_load,
  input  logic       i_load_dead,
  input  disp_grp_t  i_disp,
  input  done_rpt_t  i_done_rpt [DONE_PORTS],
  input  br_upd_t    i_br_upd,
  input  logic       i_retire,
  input  logic       i_kill,
  output rob_entry_t o_entry,
  output logic       o_all_done
);

  logic                 r_valid;
  logic                 r_dead;
  logic                 r_wrap;   // Wrap bit of the current occupant
  logic [DISP_SIZE-1:0] r_grp_id;
  logic [DISP_SIZE-1:0] r_done_grp_id;
  logic [DISP_SIZE-1:0] r_except_valid;
  logic [DISP_SIZE-1:0] r_br_upd_valid;

  logic [PC_W-1:0]                r_pc;
  disp_inst_t [DISP_SIZE-1:0]     r_inst;
  except_t [DISP_SIZE-1:0]        r_except_type;
  logic [DISP_SIZE-1:0][PC_W-1:0] r_tval;
  logic [DISP_SIZE-1:0][PC_W-1:0] r_br_target;

  logic [ROB_ID_W-1:0]   w_full_id;
  logic [DONE_PORTS-1:0] w_rpt_hit;
  logic                  w_br_hit;
  logic [DISP_SIZE-1:0]  w_load_grp_id;
  logic [DISP_SIZE-1:0]  w_done_set;
  logic [DISP_SIZE-1:0]  w_except_set;
  logic [DISP_SIZE-1:0]  w_br_set;

  assign w_full_id = {r_wrap, IDX_W'(ENTRY_IDX)};

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_slot
    assign w_load_grp_id[d] = i_disp.inst[d].valid;
  end

  for (genvar p = 0; p < DONE_PORTS; p++) begin : g_port
    assign w_rpt_hit[p] = i_done_rpt[p].valid & r_valid & (i_done_rpt[p].cmt_id == w_full_id);

    a_rpt_slot_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      w_rpt_hit[p] |-> ((i_done_rpt[p].grp_oh & ~r_grp_id) == '0));
  end

  assign w_br_hit = i_br_upd.valid & r_valid & (i_br_upd.cmt_id == w_full_id);
  assign w_br_set = (w_br_hit & i_br_upd.mispredict) ? i_br_upd.grp_oh : '0;

  always_comb begin
    w_done_set   = '0;
    w_except_set = '0;
    for (int p = 0; p < DONE_PORTS; p++) begin
      if (w_rpt_hit[p]) begin
        w_done_set |= i_done_rpt[p].grp_oh;
        if (i_done_rpt[p].except_valid) w_except_set |= i_done_rpt[p].grp_oh;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_dead         <= 1'b0;
      r_wrap         <= 1'b0;
      r_grp_id       <= '0;
      r_done_grp_id  <= '0;
      r_except_valid <= '0;
      r_br_upd_valid <= '0;
    end else if (i_load) begin
      r_valid        <= 1'b1;
      r_dead         <= i_load_dead;   // Dispatched under a flush
      r_grp_id       <= w_load_grp_id;
      r_done_grp_id  <= '0;
      r_except_valid <= '0;
      r_br_upd_valid <= '0;
    end else begin
      if (i_retire) begin
        r_valid <= 1'b0;
        r_wrap  <= ~r_wrap;   // Next occupant has the other wrap
      end
      if (i_kill && r_valid) r_dead <= 1'b1;
      r_done_grp_id  <= r_done_grp_id | w_done_set;
      r_except_valid <= r_except_valid | w_except_set;
      r_br_upd_valid <= r_br_upd_valid | w_br_set;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_pc   <= i_disp.pc;
      r_inst <= i_disp.inst;
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (w_rpt_hit[p] && i_done_rpt[p].except_valid && i_done_rpt[p].grp_oh[d]) begin
          r_except_type[d] <= i_done_rpt[p].except_type;
          r_tval[d]        <= i_done_rpt[p].tval;
        end
      end
      if (w_br_set[d]) r_br_target[d] <= i_br_upd.target;
    end
  end

  always_comb begin
    o_entry.valid        = r_valid;
    o_entry.dead         = r_dead;
    o_entry.pc           = r_pc;
    o_entry.grp_id       = r_grp_id;
    o_entry.done_grp_id  = r_done_grp_id;
    o_entry.except_valid = r_except_valid;
    o_entry.br_upd_valid = r_br_upd_valid;
    o_entry.except_type  = r_except_type;
    o_entry.tval         = r_tval;
    o_entry.br_target    = r_br_target;
    o_entry.inst         = r_inst;
  end

  assign o_all_done = r_valid & (((r_done_grp_id & r_grp_id) == r_grp_id) | r_dead);

endmodule

// ==== rob_pkg.sv ====
package rob_pkg;

  localparam int DISP_SIZE       = 2;
  localparam int ROB_ENTRIES_DEF = 8;
  localparam int ROB_ID_W_DEF    = 4;   // log2(ROB_ENTRIES_DEF) + wrap bit
  localparam int DONE_PORTS      = 2;
  localparam int PC_W            = 32;
  localparam int RNID_W          = 6;
  localparam int REGIDX_W        = 5;

  typedef enum logic [3:0] {
    INST_ADDR_MISALIGN = 4'd0,
    INST_ACC_FAULT     = 4'd1,
    ILLEGAL_INST       = 4'd2,
    LOAD_ACC_FAULT     = 4'd5,
    STORE_ACC_FAULT    = 4'd7,
    INST_PAGE_FAULT    = 4'd12
  } except_t;

  // One dispatched slot, 19 bits
  typedef struct packed {
    logic                valid;
    logic                rd_valid;
    logic [REGIDX_W-1:0] rd_regidx;
    logic [RNID_W-1:0]   rd_rnid;
    logic [RNID_W-1:0]   rd_old_rnid;
  } disp_inst_t;

  typedef struct packed {
    logic                        valid;
    logic [PC_W-1:0]             pc;    // Slot i sits at pc + 4*i
    disp_inst_t [DISP_SIZE-1:0]  inst;
  } disp_grp_t;

  typedef struct packed {
    logic                    valid;
    logic [ROB_ID_W_DEF-1:0] cmt_id;
    logic [DISP_SIZE-1:0]    grp_oh;
    logic                    except_valid;
    except_t                 except_type;
    logic [PC_W-1:0]         tval;
  } done_rpt_t;

  typedef struct packed {
    logic                    valid;
    logic [ROB_ID_W_DEF-1:0] cmt_id;
    logic [DISP_SIZE-1:0]    grp_oh;
    logic                    mispredict;
    logic [PC_W-1:0]         target;
  } br_upd_t;

  typedef struct packed {
    logic                              valid;
    logic                              dead;
    logic [PC_W-1:0]                   pc;
    logic [DISP_SIZE-1:0]              grp_id;       // Valid slots
    logic [DISP_SIZE-1:0]              done_grp_id;
    logic [DISP_SIZE-1:0]              except_valid;
    logic [DISP_SIZE-1:0]              br_upd_valid;
    except_t [DISP_SIZE-1:0]           except_type;
    logic [DISP_SIZE-1:0][PC_W-1:0]    tval;
    logic [DISP_SIZE-1:0][PC_W-1:0]    br_target;
    disp_inst_t [DISP_SIZE-1:0]        inst;
  } rob_entry_t;

  typedef struct packed {
    logic                    commit;
    logic [ROB_ID_W_DEF-1:0] cmt_id;
    logic [DISP_SIZE-1:0]    grp_id;
    logic                    flush_valid;
    logic [PC_W-1:0]         upd_pc_vaddr;
    logic                    except_valid;
    except_t                 except_type;
    logic [PC_W-1:0]         epc;
    logic [PC_W-1:0]         tval;
    logic [DISP_SIZE-1:0]    dead_id;
    logic                    all_dead;
  } commit_t;

  typedef struct packed {
    logic                               commit;
    logic [DISP_SIZE-1:0]               rnid_valid;
    logic [DISP_SIZE-1:0][REGIDX_W-1:0] rd_regidx;
    logic [DISP_SIZE-1:0][RNID_W-1:0]   rd_rnid;
    logic [DISP_SIZE-1:0][RNID_W-1:0]   old_rnid;
    logic [DISP_SIZE-1:0]               dead_id;
    logic                               all_dead;
  } rnid_upd_t;

endpackage

// ==== rob_ptr.sv ====
module rob_ptr #(
  parameter int  ROB_ENTRIES = 8,
  localparam int IDX_W       = $clog2(ROB_ENTRIES),
  localparam int ROB_ID_W    = IDX_W + 1
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_in_valid,
  input  logic                i_out_valid,
  output logic [ROB_ID_W-1:0] o_in_id,
  output logic [ROB_ID_W-1:0] o_out_id,
  output logic                o_empty,
  output logic                o_full
);

  logic [ROB_ID_W-1:0] r_in_id;
  logic [ROB_ID_W-1:0] r_out_id;

  // Counters wrap naturally over 2*ROB_ENTRIES
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_id  <= '0;
      r_out_id <= '0;
    end else begin
      if (i_in_valid)  r_in_id  <= r_in_id + ROB_ID_W'(1);
      if (i_out_valid) r_out_id <= r_out_id + ROB_ID_W'(1);
    end
  end

  assign o_in_id  = r_in_id;
  assign o_out_id = r_out_id;
  assign o_empty  = (r_in_id == r_out_id);
  // Same index, opposite wrap
  assign o_full   = (r_in_id == (r_out_id ^ ROB_ID_W'(ROB_ENTRIES)));

  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_in_valid |-> !o_full);
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_out_valid |-> !o_empty);

endmodule

// ==== rob_top.f ====
rob_pkg.sv
rob_ptr.sv
rob_entry.sv
rob_commit_sel.sv
rob_credit.sv
rob_top.sv
tb_rob_top.sv

// ==== rob_top.sv ====
module rob_top
  import rob_pkg::*;
#(
  parameter int  ROB_ENTRIES = ROB_ENTRIES_DEF,
  localparam int IDX_W       = $clog2(ROB_ENTRIES),
  localparam int ROB_ID_W    = IDX_W + 1
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  disp_grp_t           i_disp,
  output logic [ROB_ID_W-1:0] o_new_cmt_id,
  input  done_rpt_t           i_done_rpt [DONE_PORTS],
  input  br_upd_t             i_br_upd,
  output commit_t             o_commit,
  output rnid_upd_t           o_rnid_upd,
  output logic                o_credit_valid,
  output logic [IDX_W:0]      o_credit_val
);

  if (ROB_ID_W != ROB_ID_W_DEF) begin : g_id_w_check
    $error("ROB_ENTRIES does not match ROB_ID_W_DEF");
  end

  rob_entry_t           w_entries [ROB_ENTRIES];
  logic [ROB_ENTRIES-1:0] w_all_done;
  logic [ROB_ID_W-1:0]  w_in_id;
  logic [ROB_ID_W-1:0]  w_out_id;
  logic [ROB_ID_W-1:0]  w_out_id_next;
  logic [IDX_W-1:0]     w_in_idx;
  logic [IDX_W-1:0]     w_out_idx;
  logic                 w_empty;
  rob_entry_t           w_head;
  logic                 w_flush;
  logic                 w_rob_left;   // Something remains after this commit
  logic                 r_killing;

  rob_ptr #(.ROB_ENTRIES(ROB_ENTRIES)) u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (i_disp.valid),
    .i_out_valid (o_commit.commit),
    .o_in_id     (w_in_id),
    .o_out_id    (w_out_id),
    .o_empty     (w_empty),
    .o_full      ()
  );

  assign w_in_idx      = w_in_id[IDX_W-1:0];
  assign w_out_idx     = w_out_id[IDX_W-1:0];
  assign w_out_id_next = w_out_id + ROB_ID_W'(1);
  assign o_new_cmt_id  = w_in_id;

  // Live flush only, dead heads never redirect
  assign w_flush    = o_commit.commit & o_commit.flush_valid;
  assign w_rob_left = (w_in_id != w_out_id_next) | i_disp.valid;

  for (genvar c = 0; c < ROB_ENTRIES; c++) begin : g_entry
    rob_entry #(
      .ROB_ENTRIES (ROB_ENTRIES),
      .ENTRY_IDX   (c)
    ) u_entry (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_load      (i_disp.valid & (w_in_idx == IDX_W'(c))),
      .i_load_dead (w_flush),
      .i_disp      (i_disp),
      .i_done_rpt  (i_done_rpt),
      .i_br_upd    (i_br_upd),
      .i_retire    (o_commit.commit & (w_out_idx == IDX_W'(c))),
      .i_kill      (w_flush & (w_out_idx != IDX_W'(c))),
      .o_entry     (w_entries[c]),
      .o_all_done  (w_all_done[c])
    );
  end

  assign w_head = w_entries[w_out_idx];

  rob_commit_sel u_commit_sel (
    .i_head     (w_head),
    .i_head_id  (w_out_id),
    .i_all_done (w_all_done[w_out_idx]),
    .i_killing  (r_killing),
    .o_commit   (o_commit),
    .o_rnid_upd (o_rnid_upd)
  );

  rob_credit #(.ROB_ENTRIES(ROB_ENTRIES)) u_credit (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp.valid),
    .i_commit       (o_commit.commit),
    .o_credit_valid (o_credit_valid),
    .o_credit_val   (o_credit_val)
  );

  // Kill phase lasts until the dead groups have drained
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_killing <= 1'b0;
    end else if (w_flush && w_rob_left) begin
      r_killing <= 1'b1;
    end else if (r_killing && (w_empty || !w_head.dead)) begin
      r_killing <= 1'b0;
    end
  end

  a_dead_head_killing: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_head.valid && w_head.dead |-> r_killing);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the ROB testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tb_rob_top -f rob_top.f \
  && ./obj_dir/Vtb_rob_top > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "FAIL: no pass line"; exit 1; }
echo "PASS"
exit 0

// ==== tb_rob_top.sv ====
module tb_rob_top
  import rob_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int ID_W           = ROB_ID_W_DEF;

  // Expected state of one in-flight group
  typedef struct packed {
    logic [ID_W-1:0]                id;
    logic [PC_W-1:0]                pc;
    disp_inst_t [DISP_SIZE-1:0]     inst;
    logic [DISP_SIZE-1:0]           mask;
    logic [DISP_SIZE-1:0]           done;
    logic [DISP_SIZE-1:0]           exc;
    logic [DISP_SIZE-1:0]           br;
    logic                           dead;
    except_t [DISP_SIZE-1:0]        etype;
    logic [DISP_SIZE-1:0][PC_W-1:0] tval;
    logic [DISP_SIZE-1:0][PC_W-1:0] target;
  } grp_model_t;

  logic            clk;
  logic            reset_n;
  disp_grp_t       disp;
  done_rpt_t       done_rpt [DONE_PORTS];
  br_upd_t         br_upd;
  logic [ID_W-1:0] new_cmt_id;
  commit_t         dut_commit;
  rnid_upd_t       dut_rnid;
  logic            credit_valid;
  logic [ID_W-1:0] credit_val;

  grp_model_t      model_q [$];
  logic [ID_W-1:0] next_id     = '0;
  logic            prev_commit = 1'b0;
  logic            flush_now   = 1'b0;
  int credits  = ROB_ENTRIES_DEF;   // Held by the upstream stage
  int n_err    = 0;
  int n_checks = 0;
  int n_commit = 0;
  int n_credit = 0;
  int n_flush  = 0;
  int n_dead   = 0;
  int n_except = 0;
  int cycles   = 0;

  rob_top #(.ROB_ENTRIES(ROB_ENTRIES_DEF)) dut_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_disp         (disp),
    .o_new_cmt_id   (new_cmt_id),
    .i_done_rpt     (done_rpt),
    .i_br_upd       (br_upd),
    .o_commit       (dut_commit),
    .o_rnid_upd     (dut_rnid),
    .o_credit_valid (credit_valid),
    .o_credit_val   (credit_val)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Commit fields worked out from the head group's model state
  task automatic compare_commit(input grp_model_t g, output logic flush);
    int                   sel;
    int                   sel_i;
    int                   d;
    logic                 exc;
    logic [PC_W-1:0]      epc;
    logic [PC_W-1:0]      exp_tval;
    logic [DISP_SIZE-1:0] dead_id;
    logic [DISP_SIZE-1:0] rnid_valid;
    sel = -1;
    for (d = 0; d < DISP_SIZE; d++) begin
      if (sel < 0 && g.mask[d] && (g.br[d] || g.exc[d])) sel = d;
    end
    sel_i = (sel < 0) ? 0 : sel;
    flush = (sel >= 0) && !g.dead;
    exc   = flush && g.exc[sel_i];
    epc   = g.pc + PC_W'(4 * sel_i);
    exp_tval = (g.etype[sel_i] inside {INST_ADDR_MISALIGN, INST_ACC_FAULT, INST_PAGE_FAULT})
               ? epc : g.tval[sel_i];
    for (d = 0; d < DISP_SIZE; d++) begin
      dead_id[d]    = g.mask[d] && (g.dead || (sel >= 0 && d > sel));
      rnid_valid[d] = g.mask[d] && !dead_id[d] && g.inst[d].rd_valid;
    end
    check("o_commit.cmt_id", 64'(dut_commit.cmt_id), 64'(g.id));
    check("o_commit.grp_id", 64'(dut_commit.grp_id), 64'(g.mask));
    check("o_commit.all_dead", 64'(dut_commit.all_dead), 64'(g.dead));
    check("o_commit.flush_valid", 64'(dut_commit.flush_valid), 64'(flush));
    check("o_commit.except_valid", 64'(dut_commit.except_valid), 64'(exc));
    check("o_commit.dead_id", 64'(dut_commit.dead_id), 64'(dead_id));
    if (flush) begin
      check("o_commit.upd_pc_vaddr", 64'(dut_commit.upd_pc_vaddr),
            64'(exc ? epc : g.target[sel_i]));
    end
    if (exc) begin
      check("o_commit.except_type", 64'(dut_commit.except_type), 64'(g.etype[sel_i]));
      check("o_commit.epc", 64'(dut_commit.epc), 64'(epc));
      check("o_commit.tval", 64'(dut_commit.tval), 64'(exp_tval));
    end
    check("o_rnid_upd.rnid_valid", 64'(dut_rnid.rnid_valid), 64'(rnid_valid));
    check("o_rnid_upd.dead_id", 64'(dut_rnid.dead_id), 64'(dead_id));
    check("o_rnid_upd.all_dead", 64'(dut_rnid.all_dead), 64'(g.dead));
    for (d = 0; d < DISP_SIZE; d++) begin
      if (g.mask[d]) begin
        check("o_rnid_upd.rd_regidx", 64'(dut_rnid.rd_regidx[d]), 64'(g.inst[d].rd_regidx));
        check("o_rnid_upd.rd_rnid", 64'(dut_rnid.rd_rnid[d]), 64'(g.inst[d].rd_rnid));
        check("o_rnid_upd.old_rnid", 64'(dut_rnid.old_rnid[d]), 64'(g.inst[d].rd_old_rnid));
      end
    end
    // Tallies of what the DUT actually showed
    if (dut_commit.flush_valid) n_flush++;
    if (dut_commit.except_valid) n_except++;
    if (dut_commit.all_dead) n_dead++;
  endtask

  task automatic retire_check(output logic committed);
    grp_model_t g;
    logic       exp_commit;
    int         i;
    exp_commit = 1'b0;
    flush_now  = 1'b0;
    g          = '0;
    if (model_q.size() != 0) begin
      g = model_q[0];
      exp_commit = g.dead || ((g.done & g.mask) == g.mask);
    end
    check("o_commit.commit", 64'(dut_commit.commit), 64'(exp_commit));
    check("o_rnid_upd.commit", 64'(dut_rnid.commit), 64'(exp_commit));
    if (dut_commit.commit) n_commit++;
    if (exp_commit && dut_commit.commit) begin
      void'(model_q.pop_front());
      compare_commit(g, flush_now);
      // Everything younger is killed
      for (i = 0; i < model_q.size(); i++) begin
        g = model_q[i];
        if (flush_now) g.dead = 1'b1;
        model_q[i] = g;
      end
    end
    committed = exp_commit;
  endtask

  // Record this edge's dispatch and reports in the model
  task automatic apply_inputs();
    grp_model_t g;
    int         i;
    int         p;
    int         d;
    if (disp.valid) begin
      check("o_new_cmt_id", 64'(new_cmt_id), 64'(next_id));
      g      = '0;
      g.id   = next_id;
      g.pc   = disp.pc;
      g.inst = disp.inst;
      g.dead = flush_now;   // Loaded under a flush
      for (d = 0; d < DISP_SIZE; d++) g.mask[d] = disp.inst[d].valid;
      model_q.push_back(g);
      next_id = next_id + ID_W'(1);
    end
    for (i = 0; i < model_q.size(); i++) begin
      g = model_q[i];
      for (p = 0; p < DONE_PORTS; p++) begin
        if (done_rpt[p].valid && done_rpt[p].cmt_id == g.id) begin
          g.done = g.done | done_rpt[p].grp_oh;
          for (d = 0; d < DISP_SIZE; d++) begin
            if (done_rpt[p].except_valid && done_rpt[p].grp_oh[d]) begin
              g.exc[d]   = 1'b1;
              g.etype[d] = done_rpt[p].except_type;
              g.tval[d]  = done_rpt[p].tval;
            end
          end
        end
      end
      for (d = 0; d < DISP_SIZE; d++) begin
        if (br_upd.valid && br_upd.mispredict && br_upd.cmt_id == g.id && br_upd.grp_oh[d]) begin
          g.br[d]     = 1'b1;
          g.target[d] = br_upd.target;
        end
      end
      model_q[i] = g;
    end
  endtask

  always @(posedge clk) begin
    if (!reset_n) begin
      prev_commit = 1'b0;
    end else begin
      // Credit comes one cycle after its commit
      check("o_credit_valid", 64'(credit_valid), 64'(prev_commit));
      if (credit_valid) begin
        check("o_credit_val", 64'(credit_val), 64'(1));
        n_credit++;
        credits++;
      end
      retire_check(prev_commit);
      apply_inputs();
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d groups never committed", cycles, model_q.size());
      $display("Test failed");
      $finish;
    end
  end

  task automatic clear_reports();
    int p;
    for (p = 0; p < DONE_PORTS; p++) done_rpt[p] = '0;
    br_upd = '0;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    clear_reports();
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) @(negedge clk);
  endtask

  task automatic dispatch(input logic [DISP_SIZE-1:0] mask, output logic [ID_W-1:0] id);
    disp_grp_t g;
    int        d;
    while (credits == 0) @(negedge clk);
    g       = '0;
    g.valid = 1'b1;
    g.pc    = $urandom() & 32'hffff_fffc;
    for (d = 0; d < DISP_SIZE; d++) begin
      g.inst[d].valid       = mask[d];
      g.inst[d].rd_valid    = 1'($urandom_range(0, 1));
      g.inst[d].rd_regidx   = REGIDX_W'($urandom());
      g.inst[d].rd_rnid     = RNID_W'($urandom());
      g.inst[d].rd_old_rnid = RNID_W'($urandom());
    end
    id   = next_id;
    disp = g;
    credits--;
    @(negedge clk);
    disp = '0;
  endtask

  task automatic send_done(input int port, input logic [ID_W-1:0] id,
                           input logic [DISP_SIZE-1:0] oh, input logic exc,
                           input except_t etype, input logic [PC_W-1:0] tval);
    done_rpt[port].valid        = 1'b1;
    done_rpt[port].cmt_id       = id;
    done_rpt[port].grp_oh       = oh;
    done_rpt[port].except_valid = exc;
    done_rpt[port].except_type  = etype;
    done_rpt[port].tval         = tval;
  endtask

  task automatic send_branch(input logic [ID_W-1:0] id, input logic [DISP_SIZE-1:0] oh,
                             input logic [PC_W-1:0] target);
    br_upd.valid      = 1'b1;
    br_upd.cmt_id     = id;
    br_upd.grp_oh     = oh;
    br_upd.mispredict = 1'b1;
    br_upd.target     = target;
  endtask

  task automatic test_out_of_order();
    logic [ID_W-1:0] ids [4];
    int              slots [$];   // Group index * 2 + slot
    int              i;
    int              j;
    int              tmp;
    int              base;
    base = n_commit;
    for (i = 0; i < 4; i++) dispatch(2'b11, ids[i]);
    for (i = 0; i < 8; i++) slots.push_back(i);
    for (i = 7; i > 0; i--) begin
      j        = int'($urandom_range(0, i));
      tmp      = slots[i];
      slots[i] = slots[j];
      slots[j] = tmp;
    end
    i = 0;
    while (i < 8) begin
      send_done(0, ids[slots[i] / 2], DISP_SIZE'(1) << (slots[i] % 2), 1'b0,
                INST_ADDR_MISALIGN, '0);
      i++;
      if (i < 8 && $urandom_range(0, 1) == 1) begin   // Second port now and then
        send_done(1, ids[slots[i] / 2], DISP_SIZE'(1) << (slots[i] % 2), 1'b0,
                  INST_ADDR_MISALIGN, '0);
        i++;
      end
      next_cycle();
    end
    wait_drain();
    check("commits in out-of-order test", 64'(n_commit - base), 64'(4));
  endtask

  task automatic test_partial_wrap();
    logic [ID_W-1:0]      id;
    logic [DISP_SIZE-1:0] mask;
    bit                   both;
    int                   i;
    int                   d;
    int                   base;
    base = n_commit;
    for (i = 0; i < 20; i++) begin
      mask = DISP_SIZE'($urandom_range(1, 3));
      both = 1'($urandom_range(0, 1));
      dispatch(mask, id);
      for (d = 0; d < DISP_SIZE; d++) begin
        if (mask[d]) begin
          send_done(d, id, DISP_SIZE'(1) << d, 1'b0, INST_ADDR_MISALIGN, '0);
          if (!both) next_cycle();
        end
      end
      if (both) next_cycle();
      wait_drain();
    end
    check("commits in wrap test", 64'(n_commit - base), 64'(20));
  endtask

  task automatic test_mispredict();
    logic [ID_W-1:0] ids [4];
    int              i;
    int              f0;
    int              d0;
    f0 = n_flush;
    d0 = n_dead;
    for (i = 0; i < 4; i++) dispatch(2'b11, ids[i]);
    send_branch(ids[0], 2'b01, $urandom() & 32'hffff_fffc);
    send_done(0, ids[0], 2'b01, 1'b0, INST_ADDR_MISALIGN, '0);
    send_done(1, ids[0], 2'b10, 1'b0, INST_ADDR_MISALIGN, '0);
    next_cycle();
    wait_drain();
    check("flushes in mispredict test", 64'(n_flush - f0), 64'(1));
    check("dead commits in mispredict test", 64'(n_dead - d0), 64'(3));
  endtask

  task automatic test_exceptions();
    logic [ID_W-1:0] id;
    int              e0;
    e0 = n_except;
    dispatch(2'b11, id);
    send_done(0, id, 2'b01, 1'b0, INST_ADDR_MISALIGN, '0);
    send_done(1, id, 2'b10, 1'b1, INST_PAGE_FAULT, $urandom());
    next_cycle();
    wait_drain();
    dispatch(2'b11, id);
    send_done(0, id, 2'b01, 1'b1, LOAD_ACC_FAULT, $urandom());
    send_done(1, id, 2'b10, 1'b0, INST_ADDR_MISALIGN, '0);
    next_cycle();
    wait_drain();
    check("exceptions in exception test", 64'(n_except - e0), 64'(2));
  endtask

  task automatic test_credits();
    repeat (3) @(negedge clk);
    check("credit pulses vs commits", 64'(n_credit), 64'(n_commit));
    check("credits held upstream", 64'(credits), 64'(ROB_ENTRIES_DEF));
  endtask

  initial begin
    void'($urandom(32'hbd8b));
    reset_n = 1'b0;
    disp    = '0;
    clear_reports();
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    test_out_of_order();
    test_partial_wrap();
    test_mispredict();
    test_exceptions();
    test_credits();
    $display("Checks: %0d, errors: %0d, commits: %0d, credits: %0d",
             n_checks, n_err, n_commit, n_credit);
    if (n_err == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
